/* hdl/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

    localparam int xlen       = 32;
    localparam int line_halfs = 4;               // 16-bit parcels per line
    localparam int line_bits  = line_halfs * 16;
    localparam int line_bytes = line_halfs * 2;

    typedef logic [xlen-1:0] line_addr_t;       // low bits always zero

    typedef struct packed {
        line_addr_t addr;
        logic       epoch;
    } fetch_req_t;

    typedef struct packed {
        line_addr_t           addr;
        logic                 epoch;             // echoed from the request
        logic [line_bits-1:0] data;
    } fetch_resp_t;

    typedef struct packed {
        line_addr_t           addr;
        logic [line_bits-1:0] data;
    } line_entry_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] ir;                     // upper half zero when compressed
        logic            compressed;
        logic            is_branch;
        logic            is_jal;
        logic            is_jalr;
    } fetch_inst_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
    } redirect_t;

    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;

    // compressed forms, quadrant in ir[1:0] and funct in the top bits
    localparam logic [1:0] c_j_quad    = 2'b01;
    localparam logic [2:0] c_j_funct3  = 3'b101;
    localparam logic [1:0] c_bz_quad   = 2'b01;
    localparam logic [1:0] c_bz_funct2 = 2'b11;  // ir[15:14], beqz and bnez
    localparam logic [1:0] c_jr_quad   = 2'b10;
    localparam logic [2:0] c_jr_funct3 = 3'b100;

endpackage

`default_nettype wire

/* hdl/fetch_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_queue #(
    parameter int  depth     = 4,
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     flush,
    input  logic     push,
    input  payload_t din,
    output logic     full,
    input  logic     pop,
    output payload_t dout,
    output logic     empty
);
    localparam int idx_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    payload_t         mem [depth];
    logic [idx_w-1:0] head;
    logic [idx_w-1:0] tail;
    logic [cnt_w-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign full    = count == cnt_w'(depth);
    assign empty   = count == '0;
    assign dout    = mem[head];   // head entry, valid when not empty
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                tail <= (tail == idx_w'(depth - 1)) ? '0 : tail + 1'b1;
            end
            if (do_pop) begin
                head <= (head == idx_w'(depth - 1)) ? '0 : head + 1'b1;
            end
            count <= count + cnt_w'(do_push) - cnt_w'(do_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[tail] <= din;
        end
    end

    // producers are expected to honour full and empty themselves
    assert property (@(posedge clk) disable iff (rst || flush) push |-> !full)
        else $error("fetch_queue: push while full");
    assert property (@(posedge clk) disable iff (rst || flush) pop |-> !empty)
        else $error("fetch_queue: pop while empty");

endmodule

`default_nettype wire

/* hdl/pc_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module pc_gen #(
    parameter logic [fetch_pkg::xlen-1:0] reset_pc   = 32'h0000_1000,
    parameter int                         line_depth = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  fetch_pkg::redirect_t  flush,
    output logic                  req_valid,
    output fetch_pkg::fetch_req_t req,
    input  logic                  req_ready,
    input  logic                  line_pop
);
    import fetch_pkg::*;

    localparam int         cred_w    = $clog2(line_depth + 1);
    localparam line_addr_t line_mask = ~line_addr_t'(line_bytes - 1);

    line_addr_t        line_addr;
    logic              epoch;
    logic              running;   // low until the first edge out of reset
    logic [cred_w-1:0] credits;   // lines requested or queued
    logic              fire;

    assign req_valid = running && (credits < cred_w'(line_depth));
    assign req.addr  = line_addr;
    assign req.epoch = epoch;
    assign fire      = req_valid && req_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            running   <= 1'b0;
            line_addr <= reset_pc & line_mask;
            epoch     <= 1'b0;
            credits   <= '0;
        end else begin
            running <= 1'b1;
            if (flush.valid) begin
                line_addr <= flush.pc & line_mask;
                epoch     <= ~epoch;  // old responses now mismatch
                credits   <= '0;      // old lines never reach the queue
            end else begin
                if (fire) begin
                    line_addr <= line_addr + line_addr_t'(line_bytes);
                end
                credits <= credits + cred_w'(fire) - cred_w'(line_pop);
            end
        end
    end

    // pops come back from line_buffer, so the bound holds across both modules
    assert property (@(posedge clk) disable iff (rst) credits <= cred_w'(line_depth))
        else $error("pc_gen: credit count above line_depth");

endmodule

`default_nettype wire

/* hdl/line_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module line_buffer #(
    parameter int line_depth = 4
) (
    input  logic                   clk,
    input  logic                   rst,
    input  fetch_pkg::redirect_t   flush,
    input  logic                   epoch,
    input  logic                   resp_valid,
    input  fetch_pkg::fetch_resp_t resp,
    output logic                   line_valid,
    output fetch_pkg::line_entry_t line,
    input  logic                   line_ready,
    output logic                   line_pop
);
    import fetch_pkg::*;

    logic        push;
    logic        empty;
    line_entry_t entry;

    // the epoch flips one cycle after flush, so block pushes in that cycle too
    assign push       = resp_valid && !flush.valid && (resp.epoch == epoch);
    assign entry.addr = resp.addr;
    assign entry.data = resp.data;
    assign line_valid = !empty;
    assign line_pop   = line_valid && line_ready;   // returns one credit

    fetch_queue #(
        .depth     (line_depth),
        .payload_t (line_entry_t)
    ) line_queue (
        .clk   (clk),
        .rst   (rst),
        .flush (flush.valid),
        .push  (push),
        .din   (entry),
        .full  (),
        .pop   (line_pop),
        .dout  (line),
        .empty (empty)
    );

endmodule

`default_nettype wire

/* hdl/inst_aligner.sv */
`timescale 1ns/1ps
`default_nettype none

module inst_aligner #(
    parameter logic [fetch_pkg::xlen-1:0] reset_pc = 32'h0000_1000
) (
    input  logic                   clk,
    input  logic                   rst,
    input  fetch_pkg::redirect_t   flush,
    input  logic                   line_valid,
    input  fetch_pkg::line_entry_t line,
    output logic                   line_ready,
    output logic                   inst_valid,
    output fetch_pkg::fetch_inst_t inst,
    input  logic                   inst_ready
);
    import fetch_pkg::*;

    localparam int               idx_w    = $clog2(line_halfs);
    localparam logic [idx_w-1:0] last_idx = idx_w'(line_halfs - 1);

    logic [xlen-1:0]  pc;            // pc of the next instruction
    logic             carry_valid;
    logic [15:0]      carry_half;    // low parcel from the previous line
    logic [idx_w-1:0] idx;
    logic [idx_w-1:0] idx_hi;
    logic [15:0]      lo_half;
    logic [15:0]      hi_half;
    logic             is_rvc;
    logic             straddle;
    logic             last_used;
    logic             take;
    line_addr_t       pc_line;

    assign idx     = pc[idx_w:1];
    assign idx_hi  = idx + 1'b1;
    assign pc_line = pc & ~line_addr_t'(line_bytes - 1);

    assign lo_half = carry_valid ? carry_half : line.data[idx*16 +: 16];
    assign hi_half = carry_valid ? line.data[15:0] : line.data[idx_hi*16 +: 16];
    assign is_rvc  = lo_half[1:0] != 2'b11;

    // 32-bit instruction starting in the last parcel
    assign straddle  = !carry_valid && !is_rvc && (idx == last_idx);
    // the instruction uses the last parcel of the head line
    assign last_used = !carry_valid && (is_rvc ? idx == last_idx : idx_hi == last_idx);

    assign inst_valid = line_valid && !straddle;
    assign take       = inst_valid && inst_ready;
    assign line_ready = straddle || (take && last_used);

    always_comb begin
        inst    = '0;   // predecoder fills in the flags
        inst.pc = pc;
        inst.ir = is_rvc ? {16'h0000, lo_half} : {hi_half, lo_half};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc          <= reset_pc;
            carry_valid <= 1'b0;
        end else if (flush.valid) begin
            pc          <= flush.pc;
            carry_valid <= 1'b0;
        end else if (line_valid && straddle) begin
            carry_valid <= 1'b1;   // pc stays on the low half
        end else if (take) begin
            pc          <= pc + (is_rvc ? xlen'(2) : xlen'(4));
            carry_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (line_valid && straddle) begin
            carry_half <= lo_half;
        end
    end

    assert property (@(posedge clk) disable iff (rst) !pc[0])
        else $error("inst_aligner: expected pc not halfword aligned");
    // lines stay contiguous between redirects, so the head must hold pc
    assert property (@(posedge clk) disable iff (rst || flush.valid)
        line_valid |-> line.addr == (carry_valid ? pc_line + line_bytes : pc_line))
        else $error("inst_aligner: head line does not hold the expected pc");

endmodule

`default_nettype wire

/* hdl/predecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module predecoder (
    input  logic                   inst_valid,
    input  fetch_pkg::fetch_inst_t inst,
    output logic                   inst_ready,
    output logic                   q_push,
    output fetch_pkg::fetch_inst_t q_din,
    input  logic                   q_full,
    output fetch_pkg::redirect_t   pd_redirect
);
    import fetch_pkg::*;

    logic [xlen-1:0] ir;
    logic            rvc;
    logic            c_j;
    logic            c_bz;
    logic            c_jr;
    logic [xlen-1:0] j_imm;
    logic [xlen-1:0] cj_imm;

    assign ir  = inst.ir;
    assign rvc = ir[1:0] != 2'b11;

    assign c_j  = ir[1:0] == c_j_quad && ir[15:13] == c_j_funct3;
    assign c_bz = ir[1:0] == c_bz_quad && ir[15:14] == c_bz_funct2;
    // c.jr and c.jalr, rs1 of zero would be c.ebreak
    assign c_jr = ir[1:0] == c_jr_quad && ir[15:13] == c_jr_funct3
                  && ir[6:2] == 5'd0 && ir[11:7] != 5'd0;

    assign j_imm  = {{12{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};
    assign cj_imm = {{21{ir[12]}}, ir[8], ir[10:9], ir[6], ir[7], ir[2], ir[11],
                     ir[5:3], 1'b0};

    always_comb begin
        q_din            = inst;
        q_din.compressed = rvc;
        if (rvc) begin
            q_din.is_branch = c_bz;
            q_din.is_jal    = c_j;
            q_din.is_jalr   = c_jr;
        end else begin
            q_din.is_branch = ir[6:0] == op_branch;
            q_din.is_jal    = ir[6:0] == op_jal;
            q_din.is_jalr   = ir[6:0] == op_jalr;  // classified only
        end
    end

    assign inst_ready = !q_full;
    assign q_push     = inst_valid && !q_full;

    // jumps are always taken, branches fall through
    assign pd_redirect.valid = q_push && q_din.is_jal;
    assign pd_redirect.pc    = inst.pc + (rvc ? cj_imm : j_imm);

endmodule

`default_nettype wire

/* hdl/fetch_frontend.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_frontend #(
    parameter logic [fetch_pkg::xlen-1:0] reset_pc   = 32'h0000_1000,
    parameter int                         line_depth = 4,
    parameter int                         inst_depth = 8
) (
    input  logic                   clk,
    input  logic                   rst,
    output logic                   req_valid,
    output fetch_pkg::fetch_req_t  req,
    input  logic                   req_ready,
    input  logic                   resp_valid,
    input  fetch_pkg::fetch_resp_t resp,
    input  fetch_pkg::redirect_t   be_redirect,
    output logic                   out_valid,
    output fetch_pkg::fetch_inst_t out,
    input  logic                   out_ready
);
    import fetch_pkg::*;

    redirect_t   flush;
    redirect_t   pd_redirect;
    logic        line_valid;
    logic        line_ready;
    logic        line_pop;
    line_entry_t line;
    logic        inst_valid;
    logic        inst_ready;
    fetch_inst_t inst;
    logic        q_push;
    logic        q_full;
    logic        q_empty;
    fetch_inst_t q_din;

    assign flush     = be_redirect.valid ? be_redirect : pd_redirect; // backend wins
    assign out_valid = !q_empty;

    pc_gen #(.reset_pc(reset_pc), .line_depth(line_depth)) pc_gen_inst (
        .clk (clk), .rst (rst), .flush (flush),
        .req_valid (req_valid), .req (req), .req_ready (req_ready),
        .line_pop (line_pop)
    );

    line_buffer #(.line_depth(line_depth)) line_buffer_inst (
        .clk (clk), .rst (rst), .flush (flush), .epoch (req.epoch),
        .resp_valid (resp_valid), .resp (resp),
        .line_valid (line_valid), .line (line), .line_ready (line_ready),
        .line_pop (line_pop)
    );

    inst_aligner #(.reset_pc(reset_pc)) inst_aligner_inst (
        .clk (clk), .rst (rst), .flush (flush),
        .line_valid (line_valid), .line (line), .line_ready (line_ready),
        .inst_valid (inst_valid), .inst (inst), .inst_ready (inst_ready)
    );

    predecoder predecoder_inst (
        .inst_valid (inst_valid), .inst (inst), .inst_ready (inst_ready),
        .q_push (q_push), .q_din (q_din), .q_full (q_full),
        .pd_redirect (pd_redirect)
    );

    // a predecoded jump keeps itself and everything older, only the backend clears
    fetch_queue #(.depth(inst_depth), .payload_t(fetch_inst_t)) inst_queue (
        .clk   (clk),
        .rst   (rst),
        .flush (be_redirect.valid),
        .push  (q_push),
        .din   (q_din),
        .full  (q_full),
        .pop   (out_valid && out_ready),
        .dout  (out),
        .empty (q_empty)
    );

endmodule

`default_nettype wire

/* tb/icache_model.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_model #(
    parameter logic [31:0] base      = 32'h0000_1000,
    parameter int          img_halfs = 256
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   req_valid,
    input  fetch_pkg::fetch_req_t  req,
    input  logic                   req_ready,
    input  logic [1:0]             latency,    // extra cycles for the next accepted request
    output logic                   resp_valid,
    output fetch_pkg::fetch_resp_t resp
);
    import fetch_pkg::*;

    logic [15:0] mem [img_halfs];              // filled by the testbench
    fetch_req_t  req_q [$];
    longint      due_q [$];
    longint      cycle = 0;

    // outside the image every halfword is made from its own address
    function automatic logic [15:0] half_at(input logic [31:0] addr);
        logic [31:0] idx;
        idx = (addr - base) >> 1;
        if (addr >= base && idx < img_halfs) begin
            return mem[idx];
        end
        return addr[31:16] ^ addr[15:0] ^ 16'h5a5a;
    endfunction

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (rst) begin
            req_q.delete();
            due_q.delete();
        end else if (req_valid && req_ready) begin
            req_q.push_back(req);
            due_q.push_back(cycle + latency);
        end
    end

    // answers in request order, one response per cycle at most
    always @(negedge clk) begin
        if (resp_valid) begin
            void'(req_q.pop_front());
            void'(due_q.pop_front());
        end
        resp_valid = 1'b0;
        resp       = '0;
        if (!rst && req_q.size() > 0 && due_q[0] <= cycle) begin
            resp_valid = 1'b1;
            resp.addr  = req_q[0].addr;
            resp.epoch = req_q[0].epoch;
            for (int h = 0; h < line_halfs; h++) begin
                resp.data[h*16 +: 16] = half_at(req_q[0].addr + 32'(2 * h));
            end
        end
    end

    initial begin
        resp_valid = 1'b0;
        resp       = '0;
    end

endmodule

`default_nettype wire

/* tb/tb_fetch_frontend.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_frontend;
    import fetch_pkg::*;

    localparam logic [31:0] reset_pc   = 32'h0000_1000;
    localparam int          line_depth = 4;
    localparam int          img_halfs  = 256;
    localparam int          n_trans    = 800;         // transfers before the run ends
    localparam int          n_redirect = 6;

    logic        clk;
    logic        rst;
    logic        req_valid;
    fetch_req_t  req;
    logic        req_ready;
    logic        resp_valid;
    fetch_resp_t resp;
    redirect_t   be_redirect;
    logic        out_valid;
    fetch_inst_t out;
    logic        out_ready;
    logic [1:0]  latency;

    logic [31:0] lfsr;
    logic [15:0] prog [img_halfs];
    int          len_tab [img_halfs];                  // 0 marks no instruction start
    logic [3:0]  flag_tab [img_halfs];                 // compressed, branch, jal, jalr
    logic [31:0] next_tab [img_halfs];
    int          starts [$];
    logic [31:0] exp_pc;
    int          transfers;
    int          since_redirect;
    int          redirects;
    int          pend [2];                             // in-flight requests per epoch
    logic        held;
    fetch_inst_t held_out;
    logic        rst_q;

    fetch_frontend #(
        .reset_pc   (reset_pc),
        .line_depth (line_depth),
        .inst_depth (8)
    ) fetch_frontend_inst (
        .clk (clk), .rst (rst),
        .req_valid (req_valid), .req (req), .req_ready (req_ready),
        .resp_valid (resp_valid), .resp (resp),
        .be_redirect (be_redirect),
        .out_valid (out_valid), .out (out), .out_ready (out_ready)
    );

    icache_model #(.base(reset_pc), .img_halfs(img_halfs)) icache_model_inst (
        .clk (clk), .rst (rst),
        .req_valid (req_valid), .req (req), .req_ready (req_ready),
        .latency (latency), .resp_valid (resp_valid), .resp (resp)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    task automatic report_fail(input string msg);
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
        $display("TEST FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic put_inst(input int pos, input int len, input logic [31:0] ir,
                            input logic [3:0] flags, input logic [31:0] next_pc);
        prog[pos]     = ir[15:0];
        len_tab[pos]  = len;
        flag_tab[pos] = flags;
        next_tab[pos] = next_pc;
        if (len == 4) begin
            prog[pos+1] = ir[31:16];
        end
        starts.push_back(pos);
    endtask

    // random mix with forward jumps over junk parcels, closed by a jump home
    task automatic build_image();
        int          pos;
        int          skip;
        logic [31:0] pc;
        logic [20:0] joff;
        logic [11:0] coff;
        pos = 0;
        for (int i = 0; i < img_halfs; i++) begin
            prog[i]    = {3'b000, 11'(rand_bits(11)), 2'b01};
            len_tab[i] = 0;
        end
        while (pos < img_halfs - 24) begin
            pc = reset_pc + 32'(2 * pos);
            case (rand_bits(3))
                0: put_inst(pos, 2, {16'h0, 3'b000, 11'(rand_bits(11)), 2'b01}, 4'b1000,
                            pc + 2);
                3: put_inst(pos, 2, {16'h0, 3'b110, 11'(rand_bits(11)), 2'b01}, 4'b1100,
                            pc + 2);
                2: put_inst(pos, 4, {17'(rand_bits(17)), 3'b000, 5'(rand_bits(5)), op_branch},
                            4'b0100, pc + 4);
                4: begin
                    skip = int'(rand_bits(3));
                    joff = 21'(4 + 2 * skip);
                    put_inst(pos, 4, {joff[20], joff[10:1], joff[11], joff[19:12], 5'd1,
                             op_jal}, 4'b0010, pc + 32'(joff));
                    pos = pos + skip;
                end
                5: begin
                    skip = int'(rand_bits(3));
                    coff = 12'(2 + 2 * skip);
                    put_inst(pos, 2, {16'h0, 3'b101, coff[11], coff[4], coff[9:8], coff[10],
                             coff[6], coff[7], coff[3:1], coff[5], 2'b01},
                             4'b1010, pc + 32'(coff));
                    pos = pos + skip;
                end
                default: put_inst(pos, 4, {17'(rand_bits(17)), 3'b000, 5'(rand_bits(5)),
                                  7'b0010011}, 4'b0000, pc + 4);
            endcase
            pos = pos + len_tab[starts[$]] / 2;
        end
        joff = 21'(-(2 * pos));
        put_inst(pos, 4, {joff[20], joff[10:1], joff[11], joff[19:12], 5'd0, op_jal},
                 4'b0010, reset_pc);
        for (int i = 0; i < img_halfs; i++) begin
            icache_model_inst.mem[i] = prog[i];
        end
    endtask

    // reference walker and checks, sampled at the rising edge
    always @(posedge clk) begin
        int          idx;
        logic [31:0] exp_ir;
        if (rst && rst_q) begin
            assert (!req_valid && !out_valid)
                else report_fail("req_valid or out_valid high during reset");
        end
        rst_q = rst;
        if (!rst) begin
            if (held) begin
                assert (out_valid && out == held_out)
                    else report_fail("out changed while stalled by out_ready");
            end
            held     = out_valid && !out_ready && !be_redirect.valid;
            held_out = out;
            if (req_valid && req_ready) begin
                pend[req.epoch] = pend[req.epoch] + 1;
            end
            if (resp_valid) begin
                pend[resp.epoch] = pend[resp.epoch] - 1;
            end
            assert (pend[req.epoch] <= line_depth)
                else report_fail($sformatf("%0d requests outstanding", pend[req.epoch]));
            if (be_redirect.valid) begin
                exp_pc         = be_redirect.pc;
                since_redirect = 0;
            end else if (out_valid && out_ready) begin
                idx = int'((exp_pc - reset_pc) >> 1);
                assert (exp_pc >= reset_pc && idx < img_halfs && len_tab[idx] != 0)
                    else report_fail($sformatf("walker left the image at %h", exp_pc));
                exp_ir = (len_tab[idx] == 2) ? {16'h0, prog[idx]} : {prog[idx+1], prog[idx]};
                assert (out.pc == exp_pc)
                    else report_fail($sformatf("pc %h, expected %h", out.pc, exp_pc));
                assert (out.ir == exp_ir)
                    else report_fail($sformatf("ir %h at %h, expected %h", out.ir, out.pc,
                                               exp_ir));
                assert ({out.compressed, out.is_branch, out.is_jal, out.is_jalr}
                        == flag_tab[idx])
                    else report_fail($sformatf("flags wrong at %h", out.pc));
                exp_pc         = next_tab[idx];
                transfers      = transfers + 1;
                since_redirect = since_redirect + 1;
            end
        end
    end

    initial begin
        #(longint'(n_trans) * 40 * 100);
        $display("timeout: only %0d of %0d instructions came out", transfers, n_trans);
        $display("TEST FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        rst            = 1'b1;
        req_ready      = 1'b0;
        out_ready      = 1'b0;
        latency        = 2'd0;
        be_redirect    = '0;
        lfsr           = 32'd94312;
        exp_pc         = reset_pc;
        transfers      = 0;
        since_redirect = 0;
        redirects      = 0;
        pend[0]        = 0;
        pend[1]        = 0;
        held           = 1'b0;
        rst_q          = 1'b0;
        build_image();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        while (transfers < n_trans) begin
            @(negedge clk);
            req_ready   = rand_bits(2) != 2'd0;
            out_ready   = 1'(rand_bits(1));
            latency     = 2'(rand_bits(2));
            be_redirect = '0;
            // space redirects and wait until no request of the other epoch is in flight
            if (since_redirect >= 40 && redirects < n_redirect && pend[~req.epoch] == 0
                    && rand_bits(3) == 3'd0) begin
                be_redirect.valid = 1'b1;
                be_redirect.pc    = reset_pc + 32'(2 * starts[rand_bits(8) % starts.size()]);
                out_ready         = 1'b0;
                redirects         = redirects + 1;
            end
        end
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
hdl/fetch_pkg.sv
hdl/fetch_queue.sv
hdl/pc_gen.sv
hdl/line_buffer.sv
hdl/inst_aligner.sv
hdl/predecoder.sv
hdl/fetch_frontend.sv
tb/icache_model.sv
tb/tb_fetch_frontend.sv

/* Bender.yml */
package:
  name: fetch_frontend

sources:
  - hdl/fetch_pkg.sv
  - hdl/fetch_queue.sv
  - hdl/pc_gen.sv
  - hdl/line_buffer.sv
  - hdl/inst_aligner.sv
  - hdl/predecoder.sv
  - hdl/fetch_frontend.sv
  - target: test
    files:
      - tb/icache_model.sv
      - tb/tb_fetch_frontend.sv
